// ==== sim.f ====
exec_pkg.sv
exec_decode.sv
alu_core.sv
muldiv_unit.sv
exec_result_stage.sv
exec_unit_top.sv
tb_clock.sv
exec_unit_properties.sv
exec_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module exec_unit_tb -f sim.f -o sim_exec \
	&& ./obj_dir/sim_exec > sim.log 2>&1 \
	|| { cat sim.log; echo "build or simulation error"; exit 1; }
cat sim.log
! grep -q "Result: FAILED" sim.log && grep -q "Result: PASSED" sim.log \
	|| { echo "simulation reported failure"; exit 1; }
echo "simulation passed"

// ==== exec_unit_tb.sv ====
`timescale 1ns/1ps

module exec_unit_tb import exec_pkg::*; ();

	localparam int CLK_NS      = 4;
	localparam int BUSY_CYCLES = 33;
	localparam int N_ALU       = 40;
	localparam int N_SHIFT     = 36;
	localparam int N_BRANCH    = 40;
	localparam int N_MULDIV    = 24;
	localparam int N_HILO      = 12;
	localparam int N_ILLEGAL   = 24;
	// Each multiply or divide is followed by MFHI and MFLO, each write by one read
	localparam int TOTAL_OPS   = N_ALU + N_SHIFT + N_BRANCH + 3 * N_MULDIV + 2 * N_HILO
		+ N_ILLEGAL;
	localparam int WATCHDOG_NS = (TOTAL_OPS * 40 + 20) * CLK_NS;

	localparam logic [5:0] ALU_FUNCTS [10] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
		6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	localparam logic [5:0] SHIFT_FUNCTS [6] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
	localparam logic [5:0] BAD_FUNCTS [16] = '{6'h01, 6'h05, 6'h0a, 6'h0b, 6'h0c, 6'h0d,
		6'h0e, 6'h0f, 6'h14, 6'h15, 6'h1c, 6'h1f, 6'h28, 6'h2c, 6'h30, 6'h3f};

	logic         clk;
	logic         rst;
	logic         in_valid;
	exec_in_t     din;
	logic         out_valid;
	exec_result_t dout;
	logic         busy;

	logic [31:0]  lfsr_state;
	logic [31:0]  m_hi;		// Model HI and LO
	logic [31:0]  m_lo;
	exec_result_t exp_q[$];		// Expected results in issue order
	int           cyc_q[$];		// Cycle each one is due
	int           cyc = 0;
	int           checks;
	int           errors;
	int           test_errors;

	tb_clock u_clk (.clk(clk));

	exec_unit_top uut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in        (din),
		.out_valid (out_valid),
		.out       (dout),
		.busy      (busy)
	);

	bind exec_unit_top exec_unit_properties u_props (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.busy      (busy),
		.out_valid (out_valid),
		.req_valid (req_valid)
	);

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = 32'd0;
		for (i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Edge values or a random word
	function automatic logic [31:0] pick_operand();
		logic [31:0] sel;
		sel = rand_bits(2);
		case (sel[1:0])
			2'd0: return 32'd0;
			2'd1: return 32'hffff_ffff;
			2'd2: return 32'h8000_0000;
			default: return rand_bits(32);
		endcase
	endfunction

	function automatic logic [31:0] r_instr(input logic [5:0] funct, input logic [4:0] shamt);
		return {6'h00, 5'd1, 5'd2, 5'd3, shamt, funct};
	endfunction

	function automatic logic [31:0] sra_ref(input logic [31:0] x, input logic [4:0] n);
		return (x >> n) | (~(32'hffff_ffff >> n) & {32{x[31]}});
	endfunction

	task automatic divide_ref(input logic [31:0] rs, input logic [31:0] rt, input bit is_signed);
		longint n;
		longint d;
		n = longint'($signed(rs));
		d = longint'($signed(rt));
		if (rt == 32'd0) begin
			m_lo = 32'hffff_ffff;
			m_hi = rs;
		end else if (is_signed) begin
			m_lo = 32'(n / d);		// Truncates toward zero
			m_hi = 32'(n % d);
		end else begin
			m_lo = rs / rt;
			m_hi = rs % rt;
		end
	endtask

	// Reference model of one instruction, keeps its own HI and LO
	task automatic model_exec(input logic [31:0] instr, input logic [31:0] rs,
			input logic [31:0] rt, output bit has_out, output exec_result_t res);
		logic [31:0] v;
		logic [5:0]  funct;
		bit          ill;
		longint      p;
		v = 32'd0;
		ill = 1'b0;
		has_out = 1'b1;
		funct = instr[5:0];
		case (instr[31:26])
			6'h00: begin
				case (funct)
					6'h00: v = rt << instr[10:6];
					6'h02: v = rt >> instr[10:6];
					6'h03: v = sra_ref(rt, instr[10:6]);
					6'h04: v = rt << rs[4:0];
					6'h06: v = rt >> rs[4:0];
					6'h07: v = sra_ref(rt, rs[4:0]);
					6'h08, 6'h09: v = rs;
					6'h10: v = m_hi;
					6'h12: v = m_lo;
					6'h11: begin
						m_hi = rs;
						has_out = 1'b0;
					end
					6'h13: begin
						m_lo = rs;
						has_out = 1'b0;
					end
					6'h18: begin
						p = longint'($signed(rs)) * longint'($signed(rt));
						{m_hi, m_lo} = p;
						has_out = 1'b0;
					end
					6'h19: begin
						{m_hi, m_lo} = {32'd0, rs} * {32'd0, rt};
						has_out = 1'b0;
					end
					6'h1a, 6'h1b: begin
						divide_ref(rs, rt, funct == 6'h1a);
						has_out = 1'b0;
					end
					6'h20, 6'h21: v = rs + rt;
					6'h22, 6'h23: v = rs - rt;
					6'h24: v = rs & rt;
					6'h25: v = rs | rt;
					6'h26: v = rs ^ rt;
					6'h27: v = ~(rs | rt);
					6'h2a: v = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
					6'h2b: v = (rs < rt) ? 32'd1 : 32'd0;
					default: ill = 1'b1;
				endcase
			end
			6'h01: begin		// Taken branch gives zero
				if (instr[20:16] == 5'd0)
					v = ($signed(rs) < 0) ? 32'd0 : 32'd1;
				else if (instr[20:16] == 5'd1)
					v = ($signed(rs) >= 0) ? 32'd0 : 32'd1;
				else
					ill = 1'b1;
			end
			6'h04: v = (rs == rt) ? 32'd0 : 32'd1;
			6'h05: v = (rs != rt) ? 32'd0 : 32'd1;
			6'h06: v = ($signed(rs) <= 0) ? 32'd0 : 32'd1;
			6'h07: v = ($signed(rs) > 0) ? 32'd0 : 32'd1;
			default: ill = 1'b1;
		endcase
		if (ill)
			v = 32'd0;
		res.value = v;
		res.zero = (v == 32'd0);
		res.illegal = ill;
	endtask

	task automatic check_result(input exec_result_t got, input exec_result_t exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch out: got value 0x%08h zero 0x%0h illegal 0x%0h, %s0x%08h %s0x%0h %s0x%0h",
				got.value, got.zero, got.illegal, "expected value ", exp.value,
				"zero ", exp.zero, "illegal ", exp.illegal);
			errors++;
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("mismatch out_valid cycle: got 0x%0h expected 0x%0h", got, exp);
			errors++;
		end
	endtask

	task automatic check_busy(input int got);
		checks++;
		if (got != BUSY_CYCLES) begin
			$display("mismatch busy cycles: got 0x%0h expected 0x%0h", got, BUSY_CYCLES);
			errors++;
		end
	endtask

	// Drives one instruction for one cycle and queues its expected result
	task automatic send(input logic [31:0] instr, input logic [31:0] rs, input logic [31:0] rt);
		bit           has_out;
		exec_result_t res;
		@(posedge clk);
		#1;
		if (busy) begin
			$display("instruction issued at cycle %0d while busy is high", cyc);
			errors++;
		end
		in_valid = 1'b1;
		din.instr = instr;
		din.rs_val = rs;
		din.rt_val = rt;
		model_exec(instr, rs, rt, has_out, res);
		if (has_out) begin
			exp_q.push_back(res);
			cyc_q.push_back(cyc + 2);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
		end
	endtask

	task automatic watch_outputs();
		exec_result_t exp_r;
		int           exp_cyc;
		forever begin
			@(negedge clk);
			if (!rst && out_valid) begin
				if (exp_q.size() == 0) begin
					$display("out_valid at cycle %0d with no request pending", cyc);
					errors++;
				end else begin
					exp_r = exp_q.pop_front();
					exp_cyc = cyc_q.pop_front();
					check_result(dout, exp_r);
					check_latency(cyc, exp_cyc);
				end
			end
		end
	endtask

	task automatic end_test(input string name);
		int t;
		t = 0;
		while (exp_q.size() > 0 && t < 8) begin
			@(posedge clk);
			t++;
		end
		if (exp_q.size() > 0) begin
			$display("%0d expected results never got out_valid", exp_q.size());
			errors += exp_q.size();
			exp_q.delete();
			cyc_q.delete();
		end
		$display("test %-8s done, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic test_alu();
		logic [31:0] rs;
		logic [31:0] rt;
		logic [3:0]  idx;
		repeat (N_ALU) begin
			idx = 4'(rand_bits(4) % 10);
			rs = rand_bits(32);
			rt = (rand_bits(3) == 32'd0) ? rs : rand_bits(32);	// Some zero results
			send(r_instr(ALU_FUNCTS[idx], 5'(rand_bits(5))), rs, rt);
		end
		idle(1);
	endtask

	task automatic test_shift();
		logic [2:0] idx;
		repeat (N_SHIFT) begin
			idx = 3'(rand_bits(3) % 6);
			send(r_instr(SHIFT_FUNCTS[idx], 5'(rand_bits(5))), rand_bits(32), pick_operand());
		end
		idle(1);
	endtask

	task automatic test_branch();
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] instr;
		logic [15:0] off;
		repeat (N_BRANCH) begin
			rs = pick_operand();
			rt = (rand_bits(2) == 32'd0) ? rs : pick_operand();
			off = 16'(rand_bits(16));
			case (3'(rand_bits(3)))
				3'd0: instr = {6'h04, 5'd1, 5'd2, off};
				3'd1: instr = {6'h05, 5'd1, 5'd2, off};
				3'd2: instr = {6'h06, 5'd1, 5'd0, off};
				3'd3: instr = {6'h07, 5'd1, 5'd0, off};
				3'd4: instr = {6'h01, 5'd1, 5'd0, off};	// BLTZ
				3'd5: instr = {6'h01, 5'd1, 5'd1, off};	// BGEZ
				3'd6: instr = r_instr(6'h08, 5'd0);
				default: instr = r_instr(6'h09, 5'd0);	// JALR
			endcase
			send(instr, rs, rt);
		end
		idle(1);
	endtask

	task automatic test_muldiv();
		logic [5:0]  f;
		logic [31:0] rs;
		logic [31:0] rt;
		int          n;
		int          i;
		for (i = 0; i < N_MULDIV; i++) begin
			f = 6'h18 + 6'(rand_bits(2));
			rs = pick_operand();
			rt = pick_operand();
			if (i < 2) begin		// Divide by zero, signed and unsigned
				f = (i == 0) ? 6'h1a : 6'h1b;
				rt = 32'd0;
			end else if (i == 2) begin
				f = 6'h1a;
				rs = 32'h8000_0000;
				rt = 32'hffff_ffff;
			end
			send(r_instr(f, 5'd0), rs, rt);
			idle(1);
			n = 0;
			@(negedge clk);
			// Busy must already be high in the cycle after issue
			if (!busy) begin
				$display("busy did not rise in the cycle after issue at cycle %0d", cyc);
				errors++;
			end
			while (busy && n < 64) begin
				n++;
				@(negedge clk);
			end
			check_busy(n);
			send(r_instr(6'h10, 5'd0), rand_bits(32), rand_bits(32));
			send(r_instr(6'h12, 5'd0), rand_bits(32), rand_bits(32));
			idle(1);
		end
	endtask

	task automatic test_hilo();
		bit wr_hi;
		repeat (N_HILO) begin
			wr_hi = (rand_bits(1) != 32'd0);
			send(r_instr(wr_hi ? 6'h11 : 6'h13, 5'd0), rand_bits(32), rand_bits(32));
			send(r_instr(wr_hi ? 6'h10 : 6'h12, 5'd0), rand_bits(32), rand_bits(32));
		end
		idle(1);
	endtask

	task automatic test_illegal();
		logic [31:0] instr;
		logic [5:0]  opc;
		logic [4:0]  rtf;
		logic [31:0] sel;
		repeat (N_ILLEGAL) begin
			sel = rand_bits(2) % 3;
			if (sel == 32'd0) begin
				opc = 6'(rand_bits(6));
				if (opc <= 6'h01 || (opc >= 6'h04 && opc <= 6'h07))
					opc = opc | 6'h08;	// Move off a defined opcode
				instr = {opc, 26'(rand_bits(26))};
			end else if (sel == 32'd1) begin
				instr = r_instr(BAD_FUNCTS[4'(rand_bits(4))], 5'(rand_bits(5)));
			end else begin
				rtf = 5'(rand_bits(5));
				if (rtf < 5'd2)
					rtf = rtf + 5'd2;
				instr = {6'h01, 5'd1, rtf, 16'(rand_bits(16))};
			end
			send(instr, rand_bits(32), rand_bits(32));
		end
		idle(1);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired with %0d results still pending", exp_q.size());
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		din = '0;
		lfsr_state = 32'hf513;
		m_hi = 32'd0;
		m_lo = 32'd0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		fork
			watch_outputs();
		join_none
		@(negedge clk);
		if (out_valid || busy) begin
			$display("out_valid or busy high right after reset");
			errors++;
		end
		test_alu();
		end_test("alu");
		test_shift();
		end_test("shift");
		test_branch();
		end_test("branch");
		test_muldiv();
		end_test("muldiv");
		test_hilo();
		end_test("hilo");
		test_illegal();
		end_test("illegal");
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== exec_unit_properties.sv ====
`timescale 1ns/1ps

module exec_unit_properties (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic busy,
	input logic out_valid,
	input logic req_valid
);

	// No issue while the multiply/divide unit works
	a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
		!(in_valid && busy))
		else $error("in_valid high while busy is high");

	// Two-cycle latency from issue to result
	a_out_after_in: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(in_valid, 2))
		else $error("out_valid without in_valid two cycles earlier");

	a_idle_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> (!out_valid && !busy && !req_valid))
		else $error("strobes or busy high in the cycle after reset");

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	localparam int HALF_PERIOD = 2;	// 4 ns period

	initial clk = 1'b0;

	always #HALF_PERIOD clk = ~clk;

endmodule

// ==== exec_unit_top.sv ====
`timescale 1ns/1ps

module exec_unit_top import exec_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         in_valid,
	input  exec_in_t     in,
	output logic         out_valid,
	output exec_result_t out,
	output logic         busy
);

	logic        req_valid;
	exec_req_t   req;
	logic [31:0] alu_y;
	hilo_t       hilo;

	exec_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in        (in),
		.req_valid (req_valid),
		.req       (req)
	);

	alu_core u_alu (
		.req   (req),
		.alu_y (alu_y)
	);

	muldiv_unit u_muldiv (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.hilo      (hilo),
		.busy      (busy)
	);

	exec_result_stage u_result (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.alu_y     (alu_y),
		.hilo      (hilo),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

// ==== exec_result_stage.sv ====
`timescale 1ns/1ps

module exec_result_stage import exec_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         req_valid,
	input  exec_req_t    req,
	input  logic [31:0]  alu_y,
	input  hilo_t        hilo,
	output logic         out_valid,
	output exec_result_t out
);

	logic [31:0] value;
	logic        has_result;

	// Result source
	always_comb begin
		if (req.unit == UNIT_HILO_RD)
			value = (req.op == OP_MFHI) ? hilo.hi : hilo.lo;
		else
			value = alu_y;
	end

	// MULDIV and HI/LO writes stay silent
	assign has_result = (req.unit != UNIT_MULDIV) & (req.unit != UNIT_HILO_WR);

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= req_valid & has_result;
		if (req_valid) begin
			out.value   <= value;
			out.zero    <= (value == 32'd0);
			out.illegal <= (req.op == OP_ILLEGAL);
		end
	end

endmodule

// ==== muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit import exec_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req_valid,
	input  exec_req_t req,
	output hilo_t     hilo,
	output logic      busy
);

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_RUN,
		MD_FIX
	} md_state_t;

	md_state_t   state;
	logic [4:0]  cnt;
	logic [63:0] acc;		// {hi, lo} working pair
	logic [31:0] opnd;		// Multiplicand or divisor magnitude
	logic        is_div;
	logic        neg_q;		// Negate product or quotient
	logic        neg_r;		// Negate remainder
	logic        dz;		// Divide by zero
	logic        start;
	logic        signed_op;
	logic        start_div;
	logic [31:0] mag_a;
	logic [31:0] mag_b;
	logic [63:0] acc_init;

	// One shift-add or restoring divide step
	function automatic logic [63:0] md_step(input logic [63:0] cur, input logic [31:0] m,
			input logic div);
		logic [32:0] s;
		logic [33:0] d;
		begin
			if (div) begin
				d = {1'b0, cur[63:31]} - {2'b00, m};
				if (d[33])
					md_step = {cur[62:0], 1'b0};
				else
					md_step = {d[31:0], cur[30:0], 1'b1};
			end else begin
				s = {1'b0, cur[63:32]} + (cur[0] ? {1'b0, m} : 33'd0);
				md_step = {s, cur[31:1]};
			end
		end
	endfunction

	assign start     = req_valid & (req.unit == UNIT_MULDIV) & (state == MD_IDLE);
	assign signed_op = (req.op == OP_MULT) | (req.op == OP_DIV);
	assign start_div = (req.op == OP_DIV) | (req.op == OP_DIVU);
	assign mag_a     = (signed_op & req.a[31]) ? -req.a : req.a;
	assign mag_b     = (signed_op & req.b[31]) ? -req.b : req.b;
	assign acc_init  = start_div ? {32'd0, mag_a} : {32'd0, mag_b};

	assign busy = (state != MD_IDLE) | (req_valid & (req.unit == UNIT_MULDIV));

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= MD_IDLE;
			hilo.hi <= 32'd0;
			hilo.lo <= 32'd0;
		end else begin
			case (state)
				MD_IDLE: begin
					if (start) begin
						state <= MD_RUN;	// First step happens here
						cnt   <= 5'd30;
						acc   <= md_step(acc_init, start_div ? mag_b : mag_a, start_div);
						opnd  <= start_div ? mag_b : mag_a;
						is_div <= start_div;
						neg_q <= signed_op & (req.a[31] ^ req.b[31]);
						neg_r <= signed_op & req.a[31];
						dz    <= start_div & (req.b == 32'd0);
					end else if (req_valid && req.unit == UNIT_HILO_WR) begin
						if (req.op == OP_MTHI)
							hilo.hi <= req.a;
						else
							hilo.lo <= req.a;
					end
				end
				MD_RUN: begin
					acc <= md_step(acc, opnd, is_div);
					if (cnt == 5'd0)
						state <= MD_FIX;
					else
						cnt <= cnt - 5'd1;
				end
				MD_FIX: begin
					state <= MD_IDLE;
					if (is_div) begin
						hilo.hi <= neg_r ? -acc[63:32] : acc[63:32];
						hilo.lo <= dz ? 32'hffff_ffff : (neg_q ? -acc[31:0] : acc[31:0]);
					end else begin
						{hilo.hi, hilo.lo} <= neg_q ? -acc : acc;
					end
				end
				default: state <= MD_IDLE;
			endcase
		end
	end

endmodule

// ==== alu_core.sv ====
`timescale 1ns/1ps

module alu_core import exec_pkg::*; (
	input  exec_req_t   req,
	output logic [31:0] alu_y
);

	logic        taken;
	logic        a_neg;
	logic        a_zero;
	logic [4:0]  var_sh;
	logic [31:0] sum;
	logic [31:0] diff;

	assign a_neg  = req.a[31];
	assign a_zero = (req.a == 32'd0);
	assign var_sh = req.a[4:0];		// Only rs[4:0] counts
	assign sum    = req.a + req.b;
	assign diff   = req.a - req.b;

	// Branch condition
	always_comb begin
		case (req.op)
			OP_BEQ:  taken = (req.a == req.b);
			OP_BNE:  taken = (req.a != req.b);
			OP_BLEZ: taken = a_neg | a_zero;
			OP_BGTZ: taken = ~a_neg & ~a_zero;
			OP_BLTZ: taken = a_neg;
			OP_BGEZ: taken = ~a_neg;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (req.op)
			OP_AND:  alu_y = req.a & req.b;
			OP_OR:   alu_y = req.a | req.b;
			OP_XOR:  alu_y = req.a ^ req.b;
			OP_NOR:  alu_y = ~(req.a | req.b);
			OP_ADDU: alu_y = sum;
			OP_SUBU: alu_y = diff;
			OP_SLTU: alu_y = {31'd0, req.a < req.b};
			OP_SLT:  alu_y = {31'd0, $signed(req.a) < $signed(req.b)};
			OP_SLL:  alu_y = req.b << req.shamt;
			OP_SRL:  alu_y = req.b >> req.shamt;
			OP_SRA:  alu_y = $signed(req.b) >>> req.shamt;	// Sign fill
			OP_SLLV: alu_y = req.b << var_sh;
			OP_SRLV: alu_y = req.b >> var_sh;
			OP_SRAV: alu_y = $signed(req.b) >>> var_sh;
			OP_BEQ,
			OP_BNE,
			OP_BLEZ,
			OP_BGTZ,
			OP_BLTZ,
			OP_BGEZ: begin
				// Zero result means the branch is taken
				alu_y = {31'd0, ~taken};
			end
			OP_JR:   alu_y = req.a;		// Target passes through
			default: alu_y = 32'd0;		// HI/LO ops and illegal
		endcase
	end

endmodule

// ==== exec_decode.sv ====
`timescale 1ns/1ps

module exec_decode import exec_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  exec_in_t  in,
	output logic      req_valid,
	output exec_req_t req
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rt_field;
	alu_op_t    op;
	unit_t      unit;

	assign opcode   = in.instr[31:26];
	assign funct    = in.instr[5:0];
	assign rt_field = in.instr[20:16];

	always_comb begin
		op = OP_ILLEGAL;
		case (opcode)
			6'h00: begin		// SPECIAL, decoded by funct
				case (funct)
					6'h00: op = OP_SLL;
					6'h02: op = OP_SRL;
					6'h03: op = OP_SRA;
					6'h04: op = OP_SLLV;
					6'h06: op = OP_SRLV;
					6'h07: op = OP_SRAV;
					6'h08, 6'h09: op = OP_JR;	// JALR link is outside this stage
					6'h10: op = OP_MFHI;
					6'h11: op = OP_MTHI;
					6'h12: op = OP_MFLO;
					6'h13: op = OP_MTLO;
					6'h18: op = OP_MULT;
					6'h19: op = OP_MULTU;
					6'h1a: op = OP_DIV;
					6'h1b: op = OP_DIVU;
					6'h20, 6'h21: op = OP_ADDU;	// No overflow trap
					6'h22, 6'h23: op = OP_SUBU;
					6'h24: op = OP_AND;
					6'h25: op = OP_OR;
					6'h26: op = OP_XOR;
					6'h27: op = OP_NOR;
					6'h2a: op = OP_SLT;
					6'h2b: op = OP_SLTU;
					default: op = OP_ILLEGAL;
				endcase
			end
			6'h01: begin		// REGIMM
				if (rt_field == 5'd0)
					op = OP_BLTZ;
				else if (rt_field == 5'd1)
					op = OP_BGEZ;
			end
			6'h04: op = OP_BEQ;
			6'h05: op = OP_BNE;
			6'h06: op = OP_BLEZ;
			6'h07: op = OP_BGTZ;
			default: op = OP_ILLEGAL;
		endcase
	end

	always_comb begin
		case (op)
			OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: unit = UNIT_MULDIV;
			OP_MFHI, OP_MFLO: unit = UNIT_HILO_RD;
			OP_MTHI, OP_MTLO: unit = UNIT_HILO_WR;
			default: unit = UNIT_ALU;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			req_valid <= 1'b0;
		else
			req_valid <= in_valid;
		if (in_valid) begin
			req.op    <= op;
			req.unit  <= unit;
			req.a     <= in.rs_val;
			req.b     <= in.rt_val;
			req.shamt <= in.instr[10:6];
		end
	end

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

	// Operation decoded from one instruction word
	typedef enum logic [4:0] {
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_ADDU,
		OP_SUBU,
		OP_SLTU,
		OP_SLT,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_SLLV,
		OP_SRLV,
		OP_SRAV,
		OP_MULT,
		OP_MULTU,
		OP_DIV,
		OP_DIVU,
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO,
		OP_BEQ,
		OP_BNE,
		OP_BLEZ,
		OP_BGTZ,
		OP_BLTZ,
		OP_BGEZ,
		OP_JR,
		OP_ILLEGAL
	} alu_op_t;

	// Block that answers a request
	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_HILO_RD,
		UNIT_MULDIV,
		UNIT_HILO_WR
	} unit_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
	} exec_in_t;

	typedef struct packed {
		alu_op_t     op;
		unit_t       unit;
		logic [31:0] a;		// rs value
		logic [31:0] b;		// rt value
		logic [4:0]  shamt;
	} exec_req_t;

	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} hilo_t;

	typedef struct packed {
		logic [31:0] value;
		logic        zero;
		logic        illegal;
	} exec_result_t;

endpackage
